//--- source/exec_consts.svh
// Execute stage sizing constants for data, tags, registers and multiply latency
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Operand and result width
`define EXEC_XLEN 32

`define EXEC_TAG_BITS 4
`define EXEC_REG_BITS 6

// Multiply latency in cycles from issue to writeback
`define EXEC_MULT_STAGES 4

`endif

//--- source/exec_pkg.sv
// Execute stage types shared by the functional units and the writeback merge
`include "exec_consts.svh"

package exec_pkg;

  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,
    OP_SUB    = 4'h1,
    OP_SLT    = 4'h2,
    OP_SLTU   = 4'h3,
    OP_AND    = 4'h4,
    OP_OR     = 4'h5,
    OP_XOR    = 4'h6,
    OP_SLL    = 4'h7,
    OP_SRL    = 4'h8,
    OP_SRA    = 4'h9,
    // Multiply class
    OP_MUL    = 4'ha,
    OP_MULH   = 4'hb,
    OP_MULHSU = 4'hc,
    OP_MULHU  = 4'hd
  } exec_op_t;

  typedef struct packed {
    logic                      valid;
    exec_op_t                  op;
    logic [`EXEC_XLEN-1:0]     opa;
    logic [`EXEC_XLEN-1:0]     opb;
    logic [`EXEC_TAG_BITS-1:0] tag;
    logic [`EXEC_REG_BITS-1:0] dest;
  } issue_t;

  typedef struct packed {
    logic                      valid;
    logic [`EXEC_TAG_BITS-1:0] tag;
    logic [`EXEC_REG_BITS-1:0] dest;
    logic [`EXEC_XLEN-1:0]     data;
  } result_t;

  function automatic logic is_mult_op(input exec_op_t op);
    return (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU) || (op == OP_MULHU);
  endfunction

endpackage

//--- source/fu_fast_int.sv
// Fast integer unit, single-cycle ALU with a result slot held until writeback grants it
`include "exec_consts.svh"

module fu_fast_int (
  input  logic              clock,
  input  logic              reset,
  input  exec_pkg::issue_t  issue,
  input  logic              fast_grant,
  output exec_pkg::result_t fast_result,
  output logic              fast_ready
);
  import exec_pkg::*;

  localparam int shamt_bits = $clog2(`EXEC_XLEN);

  logic                      capture;
  logic [shamt_bits-1:0]     shamt;
  logic [`EXEC_XLEN-1:0]     alu_out;
  logic                      slot_valid;
  logic [`EXEC_TAG_BITS-1:0] tag_q;
  logic [`EXEC_REG_BITS-1:0] dest_q;
  logic [`EXEC_XLEN-1:0]     data_q;

  // Slot frees this cycle if the merge takes it
  assign fast_ready = !slot_valid || fast_grant;
  assign capture    = issue.valid && !is_mult_op(issue.op) && fast_ready;
  assign shamt      = issue.opb[shamt_bits-1:0];

  always_comb begin
    case (issue.op)
      OP_ADD:  alu_out = issue.opa + issue.opb;
      OP_SUB:  alu_out = issue.opa - issue.opb;
      OP_SLT:  alu_out = {{(`EXEC_XLEN-1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
      OP_SLTU: alu_out = {{(`EXEC_XLEN-1){1'b0}}, issue.opa < issue.opb};
      OP_AND:  alu_out = issue.opa & issue.opb;
      OP_OR:   alu_out = issue.opa | issue.opb;
      OP_XOR:  alu_out = issue.opa ^ issue.opb;
      OP_SLL:  alu_out = issue.opa << shamt;
      OP_SRL:  alu_out = issue.opa >> shamt;
      OP_SRA:  alu_out = $signed(issue.opa) >>> shamt;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= 1'b0;
    end else if (capture) begin
      slot_valid <= 1'b1;
    end else if (fast_grant) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      tag_q  <= issue.tag;
      dest_q <= issue.dest;
      data_q <= alu_out;
    end
  end

  always_comb begin
    fast_result.valid = slot_valid;
    fast_result.tag   = tag_q;
    fast_result.dest  = dest_q;
    fast_result.data  = data_q;
  end

endmodule

//--- source/mult_pipe.sv
// Pipelined multiplier, partial products accumulated over a configurable number of stages
`include "exec_consts.svh"

module mult_pipe #(
  parameter int stages = 4
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    start,
  input  logic [1:0]              sign,
  input  logic [`EXEC_XLEN-1:0]   mcand,
  input  logic [`EXEC_XLEN-1:0]   mplier,
  output logic [2*`EXEC_XLEN-1:0] product,
  output logic                    done
);
  localparam int prod_width = 2 * `EXEC_XLEN;
  // Multiplier bits retired per stage
  localparam int slice_bits = (prod_width + stages - 1) / stages;

  logic [prod_width-1:0] mcand_ext;
  logic [prod_width-1:0] mplier_ext;
  // Operands already shifted for the stage after i
  logic [prod_width-1:0] mcand_q  [1:stages-1];
  logic [prod_width-1:0] mplier_q [1:stages-1];
  logic [prod_width-1:0] prod_q   [1:stages];
  logic [stages:1]       valid_q;

  function automatic logic [prod_width-1:0] partial(input logic [prod_width-1:0] a,
                                                    input logic [prod_width-1:0] b);
    return a * prod_width'(b[slice_bits-1:0]);
  endfunction

  // sign[1] for mcand, sign[0] for mplier
  assign mcand_ext  = {{`EXEC_XLEN{sign[1] & mcand[`EXEC_XLEN-1]}}, mcand};
  assign mplier_ext = {{`EXEC_XLEN{sign[0] & mplier[`EXEC_XLEN-1]}}, mplier};

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[1] <= start;
      for (int i = 2; i <= stages; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // First stage works straight on the extended inputs
  always_ff @(posedge clock) begin
    mcand_q[1]  <= mcand_ext << slice_bits;
    mplier_q[1] <= mplier_ext >> slice_bits;
    prod_q[1]   <= partial(mcand_ext, mplier_ext);
    for (int i = 2; i < stages; i++) begin
      mcand_q[i]  <= mcand_q[i-1] << slice_bits;
      mplier_q[i] <= mplier_q[i-1] >> slice_bits;
    end
    for (int i = 2; i <= stages; i++) begin
      prod_q[i] <= prod_q[i-1] + partial(mcand_q[i-1], mplier_q[i-1]);
    end
  end

  // Low prod_width bits of the sum equal the signed product
  assign product = prod_q[stages];
  assign done    = valid_q[stages];

endmodule

//--- source/fu_mult.sv
// Multiply unit, drives the multiplier pipeline and carries tags alongside it
`include "exec_consts.svh"

module fu_mult (
  input  logic              clock,
  input  logic              reset,
  input  exec_pkg::issue_t  issue,
  output exec_pkg::result_t mult_result
);
  import exec_pkg::*;

  typedef struct packed {
    exec_op_t                  op;
    logic [`EXEC_TAG_BITS-1:0] tag;
    logic [`EXEC_REG_BITS-1:0] dest;
  } mult_meta_t;

  logic                    start;
  logic [1:0]              sign;
  logic [2*`EXEC_XLEN-1:0] product;
  logic                    done;
  mult_meta_t              meta_q [`EXEC_MULT_STAGES];
  mult_meta_t              meta_out;

  assign start = issue.valid && is_mult_op(issue.op);

  always_comb begin
    case (issue.op)
      OP_MUL:    sign = 2'b11;
      OP_MULH:   sign = 2'b11;
      OP_MULHSU: sign = 2'b10;
      default:   sign = 2'b00;
    endcase
  end

  mult_pipe #(.stages(`EXEC_MULT_STAGES)) u_mult_pipe (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .sign   (sign),
    .mcand  (issue.opa),
    .mplier (issue.opb),
    .product(product),
    .done   (done)
  );

  // Tag pipe runs as deep as the multiplier so done lines up with its last entry
  always_ff @(posedge clock) begin
    meta_q[0] <= '{op: issue.op, tag: issue.tag, dest: issue.dest};
    for (int i = 1; i < `EXEC_MULT_STAGES; i++) begin
      meta_q[i] <= meta_q[i-1];
    end
  end

  assign meta_out = meta_q[`EXEC_MULT_STAGES-1];

  always_comb begin
    mult_result.valid = done;
    mult_result.tag   = meta_out.tag;
    mult_result.dest  = meta_out.dest;
    mult_result.data  = (meta_out.op == OP_MUL) ? product[`EXEC_XLEN-1:0]
                                                : product[2*`EXEC_XLEN-1:`EXEC_XLEN];
  end

endmodule

//--- source/writeback_merge.sv
// Writeback merge, shares the single result port between the multiply and fast units

module writeback_merge (
  input  exec_pkg::result_t fast_result,
  input  exec_pkg::result_t mult_result,
  output exec_pkg::result_t wb_result,
  output logic              fast_grant
);

  // Multiply results cannot stall, so they always win the port.
  // The fast slot waits and keeps its result until a free cycle.
  always_comb begin
    if (mult_result.valid) begin
      wb_result  = mult_result;
      fast_grant = 1'b0;
    end else begin
      wb_result  = fast_result;
      fast_grant = fast_result.valid;
    end
  end

endmodule

//--- source/exec_unit.sv
// Integer execute stage with fast ALU and pipelined multiply sharing one writeback port

module exec_unit (
  input  logic              clock,
  input  logic              reset,
  input  exec_pkg::issue_t  issue,
  output logic              fast_ready,
  output exec_pkg::result_t wb_result
);
  import exec_pkg::*;

  result_t fast_result;
  result_t mult_result;
  logic    fast_grant;

  fu_fast_int u_fast_int (
    .clock      (clock),
    .reset      (reset),
    .issue      (issue),
    .fast_grant (fast_grant),
    .fast_result(fast_result),
    .fast_ready (fast_ready)
  );

  fu_mult u_mult (
    .clock      (clock),
    .reset      (reset),
    .issue      (issue),
    .mult_result(mult_result)
  );

  writeback_merge u_merge (
    .fast_result(fast_result),
    .mult_result(mult_result),
    .wb_result  (wb_result),
    .fast_grant (fast_grant)
  );

endmodule

//--- tests/exec_unit_assertions.sv
// Execute stage protocol checks on writeback sharing, fast slot hold and issue rules
module exec_unit_assertions (
  input logic              clock,
  input logic              reset,
  input exec_pkg::issue_t  issue,
  input logic              fast_ready,
  input logic              fast_grant,
  input exec_pkg::result_t fast_result,
  input exec_pkg::result_t mult_result
);
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  int fail_count = 0;

  // Collision with a multiply result leaves the fast slot untouched
  no_drop: assert property (@(posedge clock) disable iff (reset)
    (fast_result.valid && mult_result.valid) |=> (fast_result.valid && $stable(fast_result)))
    else begin
      $error("fast result lost in a writeback collision");
      fail_count++;
    end

  // Ungranted slot keeps its contents
  fast_hold: assert property (@(posedge clock) disable iff (reset)
    (fast_result.valid && !fast_grant) |=> (fast_result.valid && $stable(fast_result)))
    else begin
      $error("fast result changed before it was granted");
      fail_count++;
    end

  issue_when_ready: assert property (@(posedge clock) disable iff (reset)
    (issue.valid && !is_mult_op(issue.op)) |-> fast_ready)
    else begin
      $error("integer op issued while the fast unit was not ready");
      fail_count++;
    end

endmodule

bind exec_unit exec_unit_assertions u_assert (
  .clock      (clock),
  .reset      (reset),
  .issue      (issue),
  .fast_ready (fast_ready),
  .fast_grant (fast_grant),
  .fast_result(fast_result),
  .mult_result(mult_result)
);

//--- tests/exec_unit_tb.sv
// Execute stage testbench, random issue checked per tag against a reference model
`include "exec_consts.svh"

module exec_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  localparam int xlen = `EXEC_XLEN;
  localparam int num_tags = 1 << `EXEC_TAG_BITS;
  localparam int stall_limit = 50;
  localparam int drain_limit = 200;

  logic    clock = 1'b0;
  logic    reset;
  issue_t  issue;
  logic    fast_ready;
  result_t wb_result;

  int    seed = 74;
  int    cycle = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    collisions = 0;
  int    issued_total = 0;
  int    retired_total = 0;
  logic  timed_out = 1'b0;
  string test_name = "reset";

  // Model state, one entry per tag plus the fast slot
  logic                      exp_busy [num_tags];
  logic [xlen-1:0]           exp_data [num_tags];
  logic [`EXEC_REG_BITS-1:0] exp_dest [num_tags];
  logic                      exp_mult [num_tags];
  int                        exp_due  [num_tags];
  logic                      slot_busy;
  logic [`EXEC_TAG_BITS-1:0] slot_tag;
  logic [`EXEC_TAG_BITS-1:0] next_tag;
  int                        outstanding;

  exec_unit uut (
    .clock     (clock),
    .reset     (reset),
    .issue     (issue),
    .fast_ready(fast_ready),
    .wb_result (wb_result)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  function automatic logic op_is_multiply(input exec_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

  function automatic logic [xlen-1:0] model_result(input exec_op_t op, input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
    logic [2*xlen-1:0] prod_ss;
    logic [2*xlen-1:0] prod_su;
    logic [2*xlen-1:0] prod_uu;
    logic [xlen-1:0]   res;
    prod_ss = {{xlen{a[xlen-1]}}, a} * {{xlen{b[xlen-1]}}, b};
    prod_su = {{xlen{a[xlen-1]}}, a} * {{xlen{1'b0}}, b};
    prod_uu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
    case (op)
      OP_ADD:    res = a + b;
      OP_SUB:    res = a - b;
      OP_SLT:    res = ($signed(a) < $signed(b)) ? 1 : 0;
      OP_SLTU:   res = (a < b) ? 1 : 0;
      OP_AND:    res = a & b;
      OP_OR:     res = a | b;
      OP_XOR:    res = a ^ b;
      OP_SLL:    res = a << b[4:0];
      OP_SRL:    res = a >> b[4:0];
      OP_SRA:    res = $signed(a) >>> b[4:0];
      OP_MUL:    res = prod_ss[xlen-1:0];
      OP_MULH:   res = prod_ss[2*xlen-1:xlen];
      OP_MULHSU: res = prod_su[2*xlen-1:xlen];
      default:   res = prod_uu[2*xlen-1:xlen];
    endcase
    return res;
  endfunction

  task automatic retire_entry(input logic [`EXEC_TAG_BITS-1:0] tag);
    check_value("valid", 64'd1, 64'(wb_result.valid));
    check_value("tag", 64'(tag), 64'(wb_result.tag));
    check_value("dest", 64'(exp_dest[tag]), 64'(wb_result.dest));
    check_value("data", 64'(exp_data[tag]), 64'(wb_result.data));
    exp_busy[tag] = 1'b0;
    outstanding--;
  endtask

  // Port goes to a due multiply first, else to the fast slot
  task automatic observe_writeback();
    logic                      due;
    logic [`EXEC_TAG_BITS-1:0] due_tag;
    due = 1'b0;
    due_tag = '0;
    if (wb_result.valid) retired_total++;
    for (int t = 0; t < num_tags; t++) begin
      if (exp_busy[t] && exp_mult[t] && exp_due[t] == cycle) begin
        due = 1'b1;
        due_tag = t[`EXEC_TAG_BITS-1:0];
      end
    end
    check_value("fast_ready", 64'(!slot_busy || !due), 64'(fast_ready));
    if (due) begin
      if (slot_busy) collisions++;
      retire_entry(due_tag);
    end else if (slot_busy) begin
      retire_entry(slot_tag);
      slot_busy = 1'b0;
    end else begin
      check_value("idle valid", 64'd0, 64'(wb_result.valid));
    end
  endtask

  // Mode 0 integer only, 1 multiply only, 2 any opcode
  task automatic issue_op(input int mode, output logic issued);
    exec_op_t                  op;
    logic [xlen-1:0]           a;
    logic [xlen-1:0]           b;
    logic [`EXEC_REG_BITS-1:0] dest;
    logic [`EXEC_TAG_BITS-1:0] tag;
    int                        pick;
    issued = 1'b0;
    tag = next_tag;
    case (mode)
      0:       pick = $unsigned($random(seed)) % 10;
      1:       pick = 10 + $unsigned($random(seed)) % 4;
      default: pick = $unsigned($random(seed)) % 14;
    endcase
    op = exec_op_t'(pick[3:0]);
    a = $random(seed);
    b = $random(seed);
    // Small values, often negative, for compare and sign corners
    if (($random(seed) & 3) == 0) a = $random(seed) % 8;
    dest = 6'($random(seed));
    if (outstanding >= num_tags || exp_busy[tag]) return;
    if (!op_is_multiply(op) && !fast_ready) return;
    issue.valid = 1'b1;
    issue.op = op;
    issue.opa = a;
    issue.opb = b;
    issue.tag = tag;
    issue.dest = dest;
    exp_busy[tag] = 1'b1;
    exp_data[tag] = model_result(op, a, b);
    exp_dest[tag] = dest;
    exp_mult[tag] = op_is_multiply(op);
    exp_due[tag] = cycle + `EXEC_MULT_STAGES;
    if (!exp_mult[tag]) begin
      slot_busy = 1'b1;
      slot_tag = tag;
    end
    next_tag = next_tag + 1'b1;
    outstanding++;
    issued_total++;
    issued = 1'b1;
  endtask

  // One cycle; mode 3 leaves the issue port idle
  task automatic step(input int mode, output logic issued);
    @(negedge clock);
    observe_writeback();
    issue = '0;
    issued = 1'b0;
    if (mode != 3) issue_op(mode, issued);
  endtask

  task automatic run_ops(input int mode, input int count);
    int   done_ops;
    int   stalled;
    logic issued;
    done_ops = 0;
    stalled = 0;
    while (done_ops < count && !timed_out) begin
      step(mode, issued);
      if (issued) begin
        done_ops++;
        stalled = 0;
      end else begin
        stalled++;
        if (stalled > stall_limit) begin
          $display("Timeout in %s: nothing could issue for %0d cycles", test_name, stall_limit);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  task automatic drain();
    int   waited;
    logic issued;
    waited = 0;
    while (outstanding > 0 && !timed_out) begin
      step(3, issued);
      waited++;
      if (waited > drain_limit) begin
        $display("Timeout in %s: %0d results never came back", test_name, outstanding);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input int err_before, input int issued_n, input int retired_n);
    check_value("retired count", 64'(issued_n), 64'(retired_n));
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("%s: %0d issued, %0d written back, %0d mismatches", test_name, issued_n,
             retired_n, errors - err_before);
  endtask

  task automatic run_test(input string name, input int mode, input int count);
    int err_before;
    int issued_before;
    int retired_before;
    test_name = name;
    err_before = errors;
    issued_before = issued_total;
    retired_before = retired_total;
    run_ops(mode, count);
    drain();
    finish_test(err_before, issued_total - issued_before, retired_total - retired_before);
  endtask

  // Integer op lands on the same cycle as a multiply result
  task automatic collision_test();
    int   err_before;
    int   issued_before;
    int   retired_before;
    int   coll_before;
    logic issued;
    test_name = "collision";
    err_before = errors;
    issued_before = issued_total;
    retired_before = retired_total;
    coll_before = collisions;
    for (int r = 0; r < 20; r++) begin
      step(1, issued);
      repeat (`EXEC_MULT_STAGES - 2) step(3, issued);
      step(0, issued);
    end
    drain();
    check_value("collisions seen", 64'd1, 64'(collisions > coll_before));
    finish_test(err_before, issued_total - issued_before, retired_total - retired_before);
  endtask

  initial begin
    logic issued;
    reset = 1'b1;
    issue = '0;
    slot_busy = 1'b0;
    slot_tag = '0;
    next_tag = '0;
    outstanding = 0;
    for (int t = 0; t < num_tags; t++) begin
      exp_busy[t] = 1'b0;
    end
    repeat (4) @(negedge clock);
    reset = 1'b0;
    // Empty model expects idle port and a ready fast unit
    repeat (3) step(3, issued);
    finish_test(0, 0, retired_total);
    run_test("fast_ops", 0, 200);
    if (!timed_out) run_test("mult_ops", 1, 200);
    if (!timed_out) collision_test();
    if (!timed_out) run_test("mixed_random", 2, 500);
    $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d, collisions %0d",
             tests_run, tests_failed, errors, uut.u_assert.fail_count, collisions);
    if (errors == 0 && !timed_out && uut.u_assert.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+source
source/exec_pkg.sv
source/fu_fast_int.sv
source/mult_pipe.sv
source/fu_mult.sv
source/writeback_merge.sv
source/exec_unit.sv
tests/exec_unit_assertions.sv
tests/exec_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module exec_unit_tb -f project.f -o exec_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/exec_unit_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
